// ==== flist.f ====
+incdir+logic
logic/axi_wr_pkg.sv
logic/axi_burst_iter.sv
logic/axil_write_issuer.sv
logic/axil_bank_router.sv
logic/reg_bank.sv
logic/axil_bank_collect.sv
logic/axi_wr_subsystem.sv
testbench/axi_wr_subsystem_asserts.sv
testbench/tb_axi_wr_subsystem.sv

// ==== logic/axi_burst_iter.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module axi_burst_iter
  import axi_wr_pkg::*;
(
  input  logic   clk,
  input  logic   i_arst_n,

  input  logic   i_awvalid,
  input  addr_t  i_awaddr,
  input  len_t   i_awlen,
  input  size_t  i_awsize,
  input  burst_t i_awburst,
  output logic   o_awready,

  output logic   o_beat_valid,
  output addr_t  o_beat_addr,
  output logic   o_beat_last,
  input  logic   i_beat_ready
);

  iter_state_t state_q;
  len_t        remaining_q;
  logic        awready_q;
  addr_t       addr_q;
  addr_t       step_q;
  logic        incr_q;

  logic        aw_accept;
  logic        beat_take;

  // AW is only taken between bursts
  assign aw_accept = i_awvalid && awready_q;
  assign beat_take = o_beat_valid && i_beat_ready;

  assign o_awready    = awready_q;
  assign o_beat_valid = (state_q == BURST);
  assign o_beat_addr  = addr_q;
  assign o_beat_last  = (remaining_q == '0);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q     <= IDLE;
      remaining_q <= '0;
      awready_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (aw_accept) begin
            state_q     <= BURST;
            remaining_q <= i_awlen;
            awready_q   <= 1'b0;
          end else begin
            awready_q <= 1'b1;
          end
        end
        BURST: begin
          if (beat_take) begin
            if (o_beat_last) begin
              // Ready for the next AW right after the final beat
              state_q   <= IDLE;
              awready_q <= 1'b1;
            end else begin
              remaining_q <= remaining_q - 1'b1;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Running address, FIXED keeps it and INCR steps by the beat size
  always_ff @(posedge clk) begin
    if (aw_accept) begin
      addr_q <= i_awaddr;
      step_q <= addr_t'(1) << i_awsize;
      incr_q <= (i_awburst != BURST_FIXED);
    end else if (beat_take && incr_q) begin
      addr_q <= addr_q + step_q;
    end
  end

endmodule

// ==== logic/axi_wr_cfg.svh ====
`ifndef AXI_WR_CFG_SVH
`define AXI_WR_CFG_SVH

// Bus widths
`define AXI_WR_ADDR_WIDTH 16
`define AXI_WR_DATA_WIDTH 32
`define AXI_WR_ID_WIDTH 4

// Register bank array
`define AXI_WR_NUM_BANKS 4
`define AXI_WR_BANK_WORDS 16

// One strobe per data byte
`define AXI_WR_STRB_WIDTH (`AXI_WR_DATA_WIDTH / 8)

// Address layout: byte lane, word offset, bank index, then out of range
`define AXI_WR_WORD_LSB 2
`define AXI_WR_WORD_BITS $clog2(`AXI_WR_BANK_WORDS)
`define AXI_WR_BANK_LSB (`AXI_WR_WORD_LSB + `AXI_WR_WORD_BITS)
`define AXI_WR_BANK_BITS $clog2(`AXI_WR_NUM_BANKS)
`define AXI_WR_SPAN_BITS (`AXI_WR_BANK_LSB + `AXI_WR_BANK_BITS)

`endif

// ==== logic/axi_wr_pkg.sv ====
`include "axi_wr_cfg.svh"

package axi_wr_pkg;

  typedef logic [`AXI_WR_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_WR_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_WR_STRB_WIDTH-1:0] strb_t;
  typedef logic [`AXI_WR_ID_WIDTH-1:0]   id_t;
  typedef logic [7:0]                    len_t;
  typedef logic [2:0]                    size_t;
  typedef logic [1:0]                    burst_t;
  typedef logic [1:0]                    resp_t;
  typedef logic [`AXI_WR_BANK_BITS-1:0]  bank_idx_t;
  typedef logic [`AXI_WR_WORD_BITS-1:0]  word_idx_t;

  // AXI burst codes, WRAP falls back to INCR
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  // Ordered so that a larger code is a worse response
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  typedef enum logic {IDLE, BURST} iter_state_t;

endpackage

// ==== logic/axi_wr_subsystem.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module axi_wr_subsystem
  import axi_wr_pkg::*;
(
  input  logic   clk,
  input  logic   i_arst_n,

  input  logic   i_s_axi_awvalid,
  input  addr_t  i_s_axi_awaddr,
  input  id_t    i_s_axi_awid,
  input  len_t   i_s_axi_awlen,
  input  size_t  i_s_axi_awsize,
  input  burst_t i_s_axi_awburst,
  output logic   o_s_axi_awready,
  input  logic   i_s_axi_wvalid,
  input  data_t  i_s_axi_wdata,
  input  strb_t  i_s_axi_wstrb,
  input  logic   i_s_axi_wlast,
  output logic   o_s_axi_wready,
  output logic   o_s_axi_bvalid,
  output id_t    o_s_axi_bid,
  output resp_t  o_s_axi_bresp,
  input  logic   i_s_axi_bready,

  input  addr_t  i_dbg_addr,
  output data_t  o_dbg_rdata
);

  logic                          aw_accept;
  logic                          beat_valid;
  logic                          beat_ready;
  logic                          beat_last;
  addr_t                         beat_addr;

  addr_t                         lite_awaddr;
  logic                          lite_awvalid;
  logic                          lite_awready;
  data_t                         lite_wdata;
  strb_t                         lite_wstrb;
  logic                          lite_wvalid;
  logic                          lite_wready;
  logic                          lite_bvalid;
  logic                          lite_bready;
  resp_t                         lite_bresp;

  logic [`AXI_WR_NUM_BANKS-1:0]  bank_awvalid;
  logic [`AXI_WR_NUM_BANKS-1:0]  bank_wvalid;
  logic [`AXI_WR_NUM_BANKS-1:0]  bank_awready;
  logic [`AXI_WR_NUM_BANKS-1:0]  bank_wready;
  logic [`AXI_WR_NUM_BANKS-1:0]  bank_bvalid;
  logic [`AXI_WR_NUM_BANKS-1:0]  bank_bready;
  resp_t [`AXI_WR_NUM_BANKS-1:0] bank_bresp;
  data_t [`AXI_WR_NUM_BANKS-1:0] bank_dbg_rdata;
  word_idx_t                     bank_word;
  data_t                         bank_wdata;
  strb_t                         bank_wstrb;
  logic                          err_bvalid;
  logic                          err_bready;

  word_idx_t                     dbg_word;
  bank_idx_t                     dbg_bank;

  // Issuer latches the ID on the AW handshake itself
  assign aw_accept = i_s_axi_awvalid && o_s_axi_awready;

  assign dbg_word = i_dbg_addr[`AXI_WR_WORD_LSB +: `AXI_WR_WORD_BITS];
  assign dbg_bank = i_dbg_addr[`AXI_WR_BANK_LSB +: `AXI_WR_BANK_BITS];

  axi_burst_iter burst_iter_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_awvalid   (i_s_axi_awvalid),
    .i_awaddr    (i_s_axi_awaddr),
    .i_awlen     (i_s_axi_awlen),
    .i_awsize    (i_s_axi_awsize),
    .i_awburst   (i_s_axi_awburst),
    .o_awready   (o_s_axi_awready),
    .o_beat_valid(beat_valid),
    .o_beat_addr (beat_addr),
    .o_beat_last (beat_last),
    .i_beat_ready(beat_ready)
  );

  // WLAST is not needed, the iterator already knows the last beat
  axil_write_issuer write_issuer_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_awvalid   (aw_accept),
    .i_awid      (i_s_axi_awid),
    .i_beat_valid(beat_valid),
    .i_beat_addr (beat_addr),
    .i_beat_last (beat_last),
    .o_beat_ready(beat_ready),
    .i_wvalid    (i_s_axi_wvalid),
    .i_wdata     (i_s_axi_wdata),
    .i_wstrb     (i_s_axi_wstrb),
    .o_wready    (o_s_axi_wready),
    .o_awaddr_l  (lite_awaddr),
    .o_awvalid_l (lite_awvalid),
    .i_awready_l (lite_awready),
    .o_wdata_l   (lite_wdata),
    .o_wstrb_l   (lite_wstrb),
    .o_wvalid_l  (lite_wvalid),
    .i_wready_l  (lite_wready),
    .i_bvalid_l  (lite_bvalid),
    .i_bresp_l   (lite_bresp),
    .o_bready_l  (lite_bready),
    .o_bvalid    (o_s_axi_bvalid),
    .o_bid       (o_s_axi_bid),
    .o_bresp     (o_s_axi_bresp),
    .i_bready    (i_s_axi_bready)
  );

  axil_bank_router bank_router_i (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_awaddr      (lite_awaddr),
    .i_awvalid     (lite_awvalid),
    .o_awready     (lite_awready),
    .i_wdata       (lite_wdata),
    .i_wstrb       (lite_wstrb),
    .i_wvalid      (lite_wvalid),
    .o_wready      (lite_wready),
    .o_bank_awvalid(bank_awvalid),
    .o_bank_wvalid (bank_wvalid),
    .i_bank_awready(bank_awready),
    .i_bank_wready (bank_wready),
    .o_word        (bank_word),
    .o_wdata       (bank_wdata),
    .o_wstrb       (bank_wstrb),
    .o_err_bvalid  (err_bvalid),
    .i_err_bready  (err_bready)
  );

  for (genvar b = 0; b < `AXI_WR_NUM_BANKS; b++) begin : g_bank
    reg_bank reg_bank_i (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_awvalid  (bank_awvalid[b]),
      .o_awready  (bank_awready[b]),
      .i_wvalid   (bank_wvalid[b]),
      .o_wready   (bank_wready[b]),
      .i_word     (bank_word),
      .i_wdata    (bank_wdata),
      .i_wstrb    (bank_wstrb),
      .o_bvalid   (bank_bvalid[b]),
      .o_bresp    (bank_bresp[b]),
      .i_bready   (bank_bready[b]),
      .i_dbg_word (dbg_word),
      .o_dbg_rdata(bank_dbg_rdata[b])
    );
  end

  axil_bank_collect bank_collect_i (
    .i_bank_bvalid   (bank_bvalid),
    .i_bank_bresp    (bank_bresp),
    .o_bank_bready   (bank_bready),
    .i_err_bvalid    (err_bvalid),
    .o_err_bready    (err_bready),
    .o_bvalid        (lite_bvalid),
    .o_bresp         (lite_bresp),
    .i_bready        (lite_bready),
    .i_bank_dbg_rdata(bank_dbg_rdata),
    .i_dbg_bank      (dbg_bank),
    .o_dbg_rdata     (o_dbg_rdata)
  );

endmodule

// ==== logic/axil_bank_collect.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module axil_bank_collect
  import axi_wr_pkg::*;
(
  input  logic [`AXI_WR_NUM_BANKS-1:0]  i_bank_bvalid,
  input  resp_t [`AXI_WR_NUM_BANKS-1:0] i_bank_bresp,
  output logic [`AXI_WR_NUM_BANKS-1:0]  o_bank_bready,
  input  logic                          i_err_bvalid,
  output logic                          o_err_bready,

  output logic                          o_bvalid,
  output resp_t                         o_bresp,
  input  logic                          i_bready,

  input  data_t [`AXI_WR_NUM_BANKS-1:0] i_bank_dbg_rdata,
  input  bank_idx_t                     i_dbg_bank,
  output data_t                         o_dbg_rdata
);

  // At most one source is active with a single beat in flight
  assign o_bvalid = (|i_bank_bvalid) || i_err_bvalid;

  always_comb begin
    o_bresp = RESP_OKAY;
    for (int b = 0; b < `AXI_WR_NUM_BANKS; b++) begin
      if (i_bank_bvalid[b]) begin
        o_bresp = i_bank_bresp[b];
      end
    end
    if (i_err_bvalid) begin
      o_bresp = RESP_DECERR;
    end
  end

  // Ready goes back only to the source that is presenting
  always_comb begin
    for (int b = 0; b < `AXI_WR_NUM_BANKS; b++) begin
      o_bank_bready[b] = i_bready && i_bank_bvalid[b];
    end
  end

  assign o_err_bready = i_bready && i_err_bvalid;

  assign o_dbg_rdata = i_bank_dbg_rdata[i_dbg_bank];

endmodule

// ==== logic/axil_bank_router.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module axil_bank_router
  import axi_wr_pkg::*;
(
  input  logic                         clk,
  input  logic                         i_arst_n,

  input  addr_t                        i_awaddr,
  input  logic                         i_awvalid,
  output logic                         o_awready,
  input  data_t                        i_wdata,
  input  strb_t                        i_wstrb,
  input  logic                         i_wvalid,
  output logic                         o_wready,

  output logic [`AXI_WR_NUM_BANKS-1:0] o_bank_awvalid,
  output logic [`AXI_WR_NUM_BANKS-1:0] o_bank_wvalid,
  input  logic [`AXI_WR_NUM_BANKS-1:0] i_bank_awready,
  input  logic [`AXI_WR_NUM_BANKS-1:0] i_bank_wready,
  output word_idx_t                    o_word,
  output data_t                        o_wdata,
  output strb_t                        o_wstrb,

  // DECERR response source
  output logic                         o_err_bvalid,
  input  logic                         i_err_bready
);

  bank_idx_t bank;
  logic      in_range;
  logic      err_ready;
  logic      err_bvalid_q;

  assign bank     = i_awaddr[`AXI_WR_BANK_LSB +: `AXI_WR_BANK_BITS];
  assign in_range = ((i_awaddr >> `AXI_WR_SPAN_BITS) == '0);
  assign o_word   = i_awaddr[`AXI_WR_WORD_LSB +: `AXI_WR_WORD_BITS];
  assign o_wdata  = i_wdata;
  assign o_wstrb  = i_wstrb;

  // Out-of-range writes are swallowed here, AW and W in one cycle
  assign err_ready = !in_range && !err_bvalid_q && i_awvalid && i_wvalid;

  assign o_awready = in_range ? i_bank_awready[bank] : err_ready;
  assign o_wready  = in_range ? i_bank_wready[bank] : err_ready;

  always_comb begin
    for (int b = 0; b < `AXI_WR_NUM_BANKS; b++) begin
      o_bank_awvalid[b] = i_awvalid && in_range && (bank == bank_idx_t'(b));
      o_bank_wvalid[b]  = i_wvalid && in_range && (bank == bank_idx_t'(b));
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      err_bvalid_q <= 1'b0;
    end else if (err_ready) begin
      err_bvalid_q <= 1'b1;
    end else if (i_err_bready) begin
      err_bvalid_q <= 1'b0;
    end
  end

  assign o_err_bvalid = err_bvalid_q;

endmodule

// ==== logic/axil_write_issuer.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module axil_write_issuer
  import axi_wr_pkg::*;
(
  input  logic  clk,
  input  logic  i_arst_n,

  // AW acceptance strobe and ID from the AXI side
  input  logic  i_awvalid,
  input  id_t   i_awid,

  input  logic  i_beat_valid,
  input  addr_t i_beat_addr,
  input  logic  i_beat_last,
  output logic  o_beat_ready,

  input  logic  i_wvalid,
  input  data_t i_wdata,
  input  strb_t i_wstrb,
  output logic  o_wready,

  output addr_t o_awaddr_l,
  output logic  o_awvalid_l,
  input  logic  i_awready_l,
  output data_t o_wdata_l,
  output strb_t o_wstrb_l,
  output logic  o_wvalid_l,
  input  logic  i_wready_l,
  input  logic  i_bvalid_l,
  input  resp_t i_bresp_l,
  output logic  o_bready_l,

  output logic  o_bvalid,
  output id_t   o_bid,
  output resp_t o_bresp,
  input  logic  i_bready
);

  logic  busy_q;
  logic  awvalid_q;
  logic  wvalid_q;
  logic  bvalid_q;
  resp_t resp_acc_q;
  id_t   id_q;
  logic  last_q;
  addr_t awaddr_q;
  data_t wdata_q;
  strb_t wstrb_q;
  id_t   bid_q;
  resp_t bresp_q;

  logic  can_take;
  logic  take;
  logic  lite_b;
  resp_t merged_resp;

  // One beat in flight, and nothing new while the AXI B waits
  assign can_take     = !busy_q && !bvalid_q;
  assign o_beat_ready = can_take && i_wvalid;
  assign o_wready     = can_take && i_beat_valid;
  assign take         = can_take && i_beat_valid && i_wvalid;

  assign lite_b      = i_bvalid_l && busy_q;
  assign merged_resp = (i_bresp_l > resp_acc_q) ? i_bresp_l : resp_acc_q;

  assign o_awaddr_l  = awaddr_q;
  assign o_awvalid_l = awvalid_q;
  assign o_wdata_l   = wdata_q;
  assign o_wstrb_l   = wstrb_q;
  assign o_wvalid_l  = wvalid_q;
  assign o_bready_l  = busy_q;
  assign o_bvalid    = bvalid_q;
  assign o_bid       = bid_q;
  assign o_bresp     = bresp_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q     <= 1'b0;
      awvalid_q  <= 1'b0;
      wvalid_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      resp_acc_q <= RESP_OKAY;
    end else begin
      if (take) begin
        busy_q    <= 1'b1;
        awvalid_q <= 1'b1;
        wvalid_q  <= 1'b1;
      end else begin
        // AW and W retire independently
        if (i_awready_l) begin
          awvalid_q <= 1'b0;
        end
        if (i_wready_l) begin
          wvalid_q <= 1'b0;
        end
      end
      if (lite_b) begin
        busy_q <= 1'b0;
        if (last_q) begin
          bvalid_q   <= 1'b1;
          resp_acc_q <= RESP_OKAY;
        end else begin
          resp_acc_q <= merged_resp;
        end
      end else if (bvalid_q && i_bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_awvalid) begin
      id_q <= i_awid;
    end
    if (take) begin
      awaddr_q <= i_beat_addr;
      wdata_q  <= i_wdata;
      wstrb_q  <= i_wstrb;
      last_q   <= i_beat_last;
    end
    // Copy out so a following AW cannot disturb a pending B
    if (lite_b && last_q) begin
      bid_q   <= id_q;
      bresp_q <= merged_resp;
    end
  end

endmodule

// ==== logic/reg_bank.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module reg_bank
  import axi_wr_pkg::*;
(
  input  logic      clk,
  input  logic      i_arst_n,

  input  logic      i_awvalid,
  output logic      o_awready,
  input  logic      i_wvalid,
  output logic      o_wready,
  input  word_idx_t i_word,
  input  data_t     i_wdata,
  input  strb_t     i_wstrb,

  output logic      o_bvalid,
  output resp_t     o_bresp,
  input  logic      i_bready,

  // Debug read, combinational
  input  word_idx_t i_dbg_word,
  output data_t     o_dbg_rdata
);

  data_t mem_q [`AXI_WR_BANK_WORDS];
  logic  bvalid_q;
  logic  accept;

  // AW and W are taken together, and only once the last B is gone
  assign accept    = !bvalid_q && i_awvalid && i_wvalid;
  assign o_awready = accept;
  assign o_wready  = accept;

  assign o_bvalid    = bvalid_q;
  assign o_bresp     = RESP_OKAY;
  assign o_dbg_rdata = mem_q[i_dbg_word];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bvalid_q <= 1'b0;
      for (int w = 0; w < `AXI_WR_BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else begin
      if (accept) begin
        bvalid_q <= 1'b1;
        // Byte lanes
        for (int b = 0; b < `AXI_WR_STRB_WIDTH; b++) begin
          if (i_wstrb[b]) begin
            mem_q[i_word][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

endmodule

// ==== testbench/axi_wr_subsystem_asserts.sv ====
`timescale 1ns/1ps

module axi_wr_subsystem_asserts
  import axi_wr_pkg::*;
(
  input logic  clk,
  input logic  i_arst_n,
  input logic  i_bvalid,
  input logic  i_bready,
  input id_t   i_bid,
  input resp_t i_bresp,
  input logic  i_beat_valid,
  input logic  i_beat_ready,
  input addr_t i_beat_addr,
  input logic  i_lite_awvalid,
  input logic  i_lite_awready,
  input logic  i_lite_wvalid,
  input logic  i_lite_wready,
  input logic  i_lite_bvalid,
  input logic  i_lite_bready
);

  logic [1:0] outstanding_q;
  int         assert_failures = 0;

  // AXI-Lite writes issued and not yet answered
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 2'(i_lite_awvalid && i_lite_awready)
                       - 2'(i_lite_bvalid && i_lite_bready);
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bid) && $stable(i_bresp))
    else begin
      $error("AXI B dropped or changed before bready");
      assert_failures++;
    end

  a_beat_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_beat_valid && !i_beat_ready |=> i_beat_valid && $stable(i_beat_addr))
    else begin
      $error("Beat dropped or changed before ready");
      assert_failures++;
    end

  a_lite_aw_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_lite_awvalid && !i_lite_awready |=> i_lite_awvalid)
    else begin
      $error("AXI-Lite awvalid dropped before awready");
      assert_failures++;
    end

  a_lite_w_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_lite_wvalid && !i_lite_wready |=> i_lite_wvalid)
    else begin
      $error("AXI-Lite wvalid dropped before wready");
      assert_failures++;
    end

  a_b_low_after_reset: assert property (@(posedge clk) !i_arst_n |=> !i_bvalid)
    else begin
      $error("AXI B valid high right after reset");
      assert_failures++;
    end

  a_one_outstanding: assert property (@(posedge clk) disable iff (!i_arst_n)
    outstanding_q <= 2'd1)
    else begin
      $error("More than one AXI-Lite write outstanding");
      assert_failures++;
    end

endmodule

bind axi_wr_subsystem axi_wr_subsystem_asserts i_asserts (
  .clk           (clk),
  .i_arst_n      (i_arst_n),
  .i_bvalid      (o_s_axi_bvalid),
  .i_bready      (i_s_axi_bready),
  .i_bid         (o_s_axi_bid),
  .i_bresp       (o_s_axi_bresp),
  .i_beat_valid  (beat_valid),
  .i_beat_ready  (beat_ready),
  .i_beat_addr   (beat_addr),
  .i_lite_awvalid(lite_awvalid),
  .i_lite_awready(lite_awready),
  .i_lite_wvalid (lite_wvalid),
  .i_lite_wready (lite_wready),
  .i_lite_bvalid (lite_bvalid),
  .i_lite_bready (lite_bready)
);

// ==== testbench/tb_axi_wr_subsystem.sv ====
`timescale 1ns/1ps
`include "axi_wr_cfg.svh"

module tb_axi_wr_subsystem
  import axi_wr_pkg::*;
();

  localparam int MEM_WORDS  = `AXI_WR_NUM_BANKS * `AXI_WR_BANK_WORDS;
  localparam int BYTES      = `AXI_WR_STRB_WIDTH;
  localparam int BANK_BYTES = `AXI_WR_BANK_WORDS * BYTES;
  // Random bursts counted at their longest, 16 beats each
  localparam int TOTAL_BEATS     = 4 + 31 + 7 + 9 + 6 * 16 + 262;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 2000;

  logic   clk = 1'b0;
  logic   arst_n;
  logic   awvalid;
  addr_t  awaddr;
  id_t    awid;
  len_t   awlen;
  size_t  awsize;
  burst_t awburst;
  logic   awready;
  logic   wvalid;
  data_t  wdata;
  strb_t  wstrb;
  logic   wlast;
  logic   wready;
  logic   bvalid;
  id_t    bid;
  resp_t  bresp;
  logic   bready;
  addr_t  dbg_addr;
  data_t  dbg_rdata;

  data_t  ref_mem [MEM_WORDS];
  data_t  beat_data [256];
  strb_t  beat_strb [256];
  resp_t  exp_resp_q [$];
  id_t    exp_id_q [$];
  integer seed;
  string  test_name;
  int     errors;
  int     test_errors_start;
  int     tests_run;
  int     tests_failed;
  int     bursts_done;
  logic   stall_en;

  axi_wr_subsystem i_dut (
    .clk            (clk),
    .i_arst_n       (arst_n),
    .i_s_axi_awvalid(awvalid),
    .i_s_axi_awaddr (awaddr),
    .i_s_axi_awid   (awid),
    .i_s_axi_awlen  (awlen),
    .i_s_axi_awsize (awsize),
    .i_s_axi_awburst(awburst),
    .o_s_axi_awready(awready),
    .i_s_axi_wvalid (wvalid),
    .i_s_axi_wdata  (wdata),
    .i_s_axi_wstrb  (wstrb),
    .i_s_axi_wlast  (wlast),
    .o_s_axi_wready (wready),
    .o_s_axi_bvalid (bvalid),
    .o_s_axi_bid    (bid),
    .o_s_axi_bresp  (bresp),
    .i_s_axi_bready (bready),
    .i_dbg_addr     (dbg_addr),
    .o_dbg_rdata    (dbg_rdata)
  );

  always #5 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Compare failures plus failed bound assertions
  function automatic int total_errors();
    return errors + i_dut.i_asserts.assert_failures;
  endfunction

  // Reference model, applies every beat and returns the worst response
  function automatic resp_t apply_burst(input addr_t start, input len_t len,
                                        input size_t size, input burst_t burst);
    int    i;
    int    b;
    addr_t a;
    resp_t worst;
    worst = RESP_OKAY;
    for (i = 0; i <= len; i++) begin
      a = (burst == BURST_FIXED) ? start : start + addr_t'(i << size);
      if (a >= MEM_WORDS * BYTES) begin
        if (RESP_DECERR > worst) begin
          worst = RESP_DECERR;
        end
      end else begin
        for (b = 0; b < BYTES; b++) begin
          if (beat_strb[i][b]) begin
            ref_mem[a / BYTES][b*8 +: 8] = beat_data[i][b*8 +: 8];
          end
        end
      end
    end
    return worst;
  endfunction

  task automatic check_resp(input resp_t exp_resp, input resp_t act_resp,
                            input id_t exp_id, input id_t act_id);
    if (act_resp !== exp_resp) begin
      $display("Fail %s: bresp expected %0d, actual %0d", test_name, exp_resp, act_resp);
      errors++;
    end
    if (act_id !== exp_id) begin
      $display("Fail %s: bid expected %0d, actual %0d", test_name, exp_id, act_id);
      errors++;
    end
  endtask

  task automatic check_word(input addr_t addr, input data_t exp_data, input data_t act_data);
    if (act_data !== exp_data) begin
      $display("Fail %s: word 0x%04h expected 0x%08h, actual 0x%08h",
               test_name, addr, exp_data, act_data);
      errors++;
    end
  endtask

  // Compares every B handshake against the queued expectation
  always @(negedge clk) begin
    if (arst_n && bvalid && bready) begin
      if (exp_resp_q.size() == 0) begin
        $display("Error in %s: a B response arrived with no burst outstanding", test_name);
        errors++;
      end else begin
        check_resp(exp_resp_q.pop_front(), bresp, exp_id_q.pop_front(), bid);
      end
      bursts_done++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the bursts did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic fill_random(input int n, input logic full);
    int i;
    for (i = 0; i < n; i++) begin
      beat_data[i] = $random(seed);
      beat_strb[i] = full ? '1 : strb_t'($random(seed));
    end
  endtask

  // Narrow beats, strobes follow the byte lanes of each address
  task automatic fill_lanes(input addr_t start, input len_t len, input size_t size);
    int    i;
    addr_t a;
    int    lane;
    for (i = 0; i <= len; i++) begin
      a = start + addr_t'(i << size);
      lane = (a % BYTES) & ~((1 << size) - 1);
      beat_data[i] = $random(seed);
      beat_strb[i] = strb_t'(((1 << (1 << size)) - 1) << lane);
    end
  endtask

  task automatic send_w(input len_t len);
    int i;
    int gap;
    for (i = 0; i <= len; i++) begin
      gap = stall_en ? rand_below(4) : 0;
      if (gap > 0) begin
        wvalid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      wvalid <= 1'b1;
      wdata  <= beat_data[i];
      wstrb  <= beat_strb[i];
      wlast  <= (i == len);
      do @(negedge clk); while (!wready);
      @(posedge clk);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
  endtask

  task automatic run_burst(input addr_t addr, input len_t len, input size_t size,
                           input burst_t burst, input id_t id);
    int target;
    int stall;
    exp_resp_q.push_back(apply_burst(addr, len, size, burst));
    exp_id_q.push_back(id);
    target = bursts_done + 1;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    awid    <= id;
    awlen   <= len;
    awsize  <= size;
    awburst <= burst;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    awvalid <= 1'b0;
    send_w(len);
    stall = stall_en ? rand_below(8) : 0;
    repeat (stall) @(posedge clk);
    bready <= 1'b1;
    while (bursts_done < target) @(posedge clk);
    bready <= 1'b0;
  endtask

  // Whole memory through the debug port
  task automatic check_memory();
    int w;
    for (w = 0; w < MEM_WORDS; w++) begin
      @(posedge clk);
      dbg_addr <= addr_t'(w * BYTES);
      @(negedge clk);
      check_word(addr_t'(w * BYTES), ref_mem[w], dbg_rdata);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors_start = total_errors();
  endtask

  task automatic finish_test();
    check_memory();
    // Each burst has had its one B, so nothing may be waiting now
    if (bvalid) begin
      $display("Error in %s: an extra B response is pending after the last burst",
               test_name);
      errors++;
    end
    tests_run++;
    if (total_errors() == test_errors_start) begin
      $display("%s: ok", test_name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", test_name, total_errors() - test_errors_start);
    end
  endtask

  initial begin
    int     b;
    addr_t  raddr;
    len_t   rlen;
    burst_t rburst;
    seed = 32'h4bf6_bd95;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    bursts_done = 0;
    stall_en = 1'b0;
    test_name = "reset";
    arst_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    awid = '0;
    awlen = '0;
    awsize = '0;
    awburst = BURST_INCR;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wlast = 1'b0;
    bready = 1'b0;
    dbg_addr = '0;
    for (b = 0; b < MEM_WORDS; b++) begin
      ref_mem[b] = '0;
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    start_test("single_beat");
    for (b = 0; b < `AXI_WR_NUM_BANKS; b++) begin
      fill_random(1, 1'b1);
      run_burst(addr_t'(b * BANK_BYTES + 8), 8'd0, 3'd2, BURST_INCR, id_t'(b + 3));
    end
    finish_test();

    start_test("incr_bursts");
    fill_random(2, 1'b1);
    run_burst(16'h0000, 8'd1, 3'd2, BURST_INCR, 4'h1);
    fill_random(5, 1'b1);
    run_burst(16'h0084, 8'd4, 3'd2, BURST_INCR, 4'h2);
    // From bank 0 into bank 1
    fill_random(8, 1'b1);
    run_burst(16'h0038, 8'd7, 3'd2, BURST_INCR, 4'h3);
    fill_random(16, 1'b1);
    run_burst(16'h00c0, 8'd15, 3'd2, BURST_INCR, 4'h4);
    finish_test();

    start_test("fixed_and_strobes");
    fill_random(4, 1'b1);
    run_burst(16'h0010, 8'd3, 3'd2, BURST_FIXED, 4'h5);
    fill_random(3, 1'b1);
    beat_strb[0] = 4'b0101;
    beat_strb[1] = 4'b1000;
    beat_strb[2] = 4'b0110;
    run_burst(16'h0050, 8'd2, 3'd2, BURST_INCR, 4'h6);
    finish_test();

    start_test("decerr");
    // Four beats in bank 3, then four past the top
    fill_random(8, 1'b1);
    run_burst(16'h00f0, 8'd7, 3'd2, BURST_INCR, 4'h9);
    fill_random(1, 1'b1);
    run_burst(16'h0200, 8'd0, 3'd2, BURST_INCR, 4'ha);
    finish_test();

    start_test("random_stalls");
    stall_en = 1'b1;
    for (b = 0; b < 6; b++) begin
      raddr  = addr_t'(rand_below(MEM_WORDS) * BYTES);
      rlen   = len_t'(rand_below(16));
      rburst = (rand_below(2) == 0) ? BURST_FIXED : BURST_INCR;
      fill_random(rlen + 1, 1'b0);
      run_burst(raddr, rlen, 3'd2, rburst, id_t'(rand_below(16)));
    end
    stall_en = 1'b0;
    finish_test();

    start_test("narrow");
    fill_lanes(16'h0000, 8'd255, 3'd0);
    run_burst(16'h0000, 8'd255, 3'd0, BURST_INCR, 4'hc);
    fill_lanes(16'h0042, 8'd5, 3'd1);
    run_burst(16'h0042, 8'd5, 3'd1, BURST_INCR, 4'hd);
    finish_test();

    $display("Tests run: %0d, tests with errors: %0d, errors: %0d",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
